// ==== logic/divPkg.sv ====
`default_nettype none

package divPkg;

    localparam int NUM_LANES = 3;
    localparam int DATA_W = 32;
    localparam int SQN_W = 6;
    localparam int TAG_W = 5;

    // Index widths derived from the sizes above.
    localparam int PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
    localparam int CNT_W = $clog2(DATA_W);

    localparam logic [DATA_W-1:0] DATA_MIN = {1'b1, {(DATA_W-1){1'b0}}};

    typedef enum logic [1:0] {
        DIV_DIV,
        DIV_DIVU,
        DIV_REM,
        DIV_REMU
    } divOp;

    typedef struct packed {
        logic [SQN_W-1:0]  sqN;
        logic [TAG_W-1:0]  tag;
        divOp              op;
        logic [DATA_W-1:0] srcA;  // Dividend.
        logic [DATA_W-1:0] srcB;  // Divisor.
    } divUop;

    typedef struct packed {
        logic [SQN_W-1:0]  sqN;
        logic [TAG_W-1:0]  tag;
        logic [DATA_W-1:0] result;
    } divResult;

    typedef struct packed {
        logic             taken;
        logic [SQN_W-1:0] sqN;
    } branchProv;

    // Sequence numbers wrap, so age comes from the signed difference.
    function automatic logic isYounger(input logic [SQN_W-1:0] a, input logic [SQN_W-1:0] b);
        logic [SQN_W-1:0] diff;
        diff = a - b;
        return $signed(diff) > 0;
    endfunction

endpackage

`default_nettype wire

// ==== logic/divDispatch.sv ====
`default_nettype none

module divDispatch import divPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 issueReq,
    output logic                 issueAck,
    input  divUop                issueUop,
    input  logic [NUM_LANES-1:0] laneIdle,
    output logic [NUM_LANES-1:0] laneStart,
    output divUop                laneUop
);

    typedef enum logic {
        DS_WAIT_REQ,
        DS_WAIT_DROP
    } dispState;

    dispState state;
    logic held;
    divUop heldUop;
    logic latch;
    logic [NUM_LANES-1:0] pick;

    // A new uop is taken only when the holding register is empty.
    assign latch = (state == DS_WAIT_REQ) && issueReq && !held;

    // Isolate the lowest set bit of the idle vector.
    assign pick = laneIdle & (~laneIdle + 1'b1);

    assign laneStart = held ? pick : '0;
    assign laneUop = heldUop;
    assign issueAck = (state == DS_WAIT_DROP);

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= DS_WAIT_REQ;
            held <= 1'b0;
        end else begin
            case (state)
                DS_WAIT_REQ: begin
                    if (latch) begin
                        state <= DS_WAIT_DROP;
                    end
                end
                DS_WAIT_DROP: begin
                    if (!issueReq) begin
                        state <= DS_WAIT_REQ;  // Ack falls once the issuer lets go.
                    end
                end
                default: state <= DS_WAIT_REQ;
            endcase

            if (|laneStart) begin
                held <= 1'b0;
            end
            if (latch) begin
                held <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (latch) begin
            heldUop <= issueUop;
        end
    end

endmodule

`default_nettype wire

// ==== logic/divLane.sv ====
`default_nettype none

module divLane import divPkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      laneStart,
    input  divUop     laneUop,
    input  branchProv branch,
    output logic      laneIdle,
    output logic      laneDone,
    output divResult  laneRes,
    input  logic      laneGrant
);

    typedef enum logic [1:0] {
        LS_IDLE,
        LS_RUN,
        LS_FIX,
        LS_DONE
    } laneState;

    laneState state;
    divUop uop;
    logic [CNT_W-1:0] cnt;
    logic [2*DATA_W:0] part;  // Signed 33-bit partial remainder above the dividend bits.
    logic [2*DATA_W:0] divTerm;
    logic [DATA_W-1:0] q;
    logic [DATA_W-1:0] d;
    logic invert;
    logic divZero;
    logic overflow;

    logic isSigned;
    logic isRem;
    logic uopRem;
    logic negA;
    logic negB;
    logic [DATA_W-1:0] absA;
    logic [DATA_W-1:0] absB;
    logic killStart;
    logic killRun;
    logic [DATA_W-1:0] qFix;
    logic [DATA_W-1:0] rFix;

    assign isSigned = (laneUop.op == DIV_DIV) || (laneUop.op == DIV_REM);
    assign isRem = (laneUop.op == DIV_REM) || (laneUop.op == DIV_REMU);
    assign uopRem = (uop.op == DIV_REM) || (uop.op == DIV_REMU);
    assign negA = isSigned && laneUop.srcA[DATA_W-1];
    assign negB = isSigned && laneUop.srcB[DATA_W-1];
    assign absA = negA ? -laneUop.srcA : laneUop.srcA;
    assign absB = negB ? -laneUop.srcB : laneUop.srcB;

    assign killStart = branch.taken && isYounger(laneUop.sqN, branch.sqN);
    assign killRun = branch.taken && isYounger(uop.sqN, branch.sqN);

    assign divTerm = {1'b0, d, {DATA_W{1'b0}}};

    // Map the +1/-1 digits back to binary, then fix up a negative final remainder.
    assign qFix = q - ~q - {{(DATA_W-1){1'b0}}, part[2*DATA_W]};
    assign rFix = part[2*DATA_W] ? part[2*DATA_W-1:DATA_W] + d : part[2*DATA_W-1:DATA_W];

    assign laneIdle = (state == LS_IDLE);
    assign laneDone = (state == LS_DONE);

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= LS_IDLE;
        end else begin
            case (state)
                LS_IDLE: begin
                    if (laneStart && !killStart) begin
                        state <= LS_RUN;
                    end
                end
                LS_RUN: begin
                    if (killRun) begin
                        state <= LS_IDLE;
                    end else if (cnt == '0) begin
                        state <= LS_FIX;
                    end
                end
                LS_FIX: state <= killRun ? LS_IDLE : LS_DONE;
                LS_DONE: begin
                    if (killRun || laneGrant) begin
                        state <= LS_IDLE;
                    end
                end
                default: state <= LS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            LS_IDLE: begin
                if (laneStart) begin
                    uop <= laneUop;
                    cnt <= '1;
                    part <= {{(DATA_W+1){1'b0}}, absA};
                    d <= absB;
                    invert <= isRem ? negA : (negA ^ negB);  // Remainder takes the dividend's sign.
                    divZero <= (laneUop.srcB == '0);
                    overflow <= isSigned && (laneUop.srcA == DATA_MIN) && (laneUop.srcB == '1);
                end
            end
            LS_RUN: begin
                q[cnt] <= !part[2*DATA_W];
                if (part[2*DATA_W]) begin
                    part <= (part << 1) + divTerm;
                end else begin
                    part <= (part << 1) - divTerm;
                end
                cnt <= cnt - 1'b1;
            end
            LS_FIX: begin
                laneRes.sqN <= uop.sqN;
                laneRes.tag <= uop.tag;
                if (divZero) begin
                    laneRes.result <= uopRem ? uop.srcA : '1;
                end else if (overflow) begin
                    laneRes.result <= uopRem ? '0 : uop.srcA;
                end else if (uopRem) begin
                    laneRes.result <= invert ? -rFix : rFix;
                end else begin
                    laneRes.result <= invert ? -qFix : qFix;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/divResultArbiter.sv ====
`default_nettype none

module divResultArbiter import divPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [NUM_LANES-1:0] laneDone,
    input  divResult             laneRes [NUM_LANES],
    output logic [NUM_LANES-1:0] laneGrant,
    output logic                 resReq,
    input  logic                 resAck,
    output divResult             res
);

    typedef enum logic [1:0] {
        AS_FREE,
        AS_REQ,
        AS_DROP
    } arbState;

    arbState state;
    logic [PTR_W-1:0] ptr;
    logic [PTR_W-1:0] pickIdx;
    logic [NUM_LANES-1:0] pickVec;
    logic anyDone;
    int idx;

    // Search starts at the pointer and wraps around the lanes.
    always_comb begin
        pickVec = '0;
        pickIdx = '0;
        anyDone = 1'b0;
        for (int i = 0; i < NUM_LANES; i++) begin
            idx = int'(ptr) + i;
            if (idx >= NUM_LANES) begin
                idx = idx - NUM_LANES;
            end
            if (laneDone[idx] && !anyDone) begin
                anyDone = 1'b1;
                pickVec[idx] = 1'b1;
                pickIdx = PTR_W'(idx);
            end
        end
    end

    assign laneGrant = (state == AS_FREE) ? pickVec : '0;
    assign resReq = (state == AS_REQ);

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= AS_FREE;
            ptr <= '0;
        end else begin
            case (state)
                AS_FREE: begin
                    if (anyDone) begin
                        state <= AS_REQ;
                        ptr <= (pickIdx == PTR_W'(NUM_LANES - 1)) ? '0 : pickIdx + 1'b1;
                    end
                end
                AS_REQ: if (resAck) state <= AS_DROP;
                AS_DROP: if (!resAck) state <= AS_FREE;  // Port is free only after ack falls.
                default: state <= AS_FREE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == AS_FREE) && anyDone) begin
            res <= laneRes[pickIdx];
        end
    end

endmodule

`default_nettype wire

// ==== logic/divCluster.sv ====
`default_nettype none

module divCluster import divPkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      issueReq,
    output logic      issueAck,
    input  divUop     issueUop,
    input  branchProv branch,
    output logic      resReq,
    input  logic      resAck,
    output divResult  res
);

    logic [NUM_LANES-1:0] laneStart;
    logic [NUM_LANES-1:0] laneIdle;
    logic [NUM_LANES-1:0] laneDone;
    logic [NUM_LANES-1:0] laneGrant;
    divUop laneUop;
    divResult laneRes [NUM_LANES];

    divDispatch dispatch (
        .clk(clk),
        .rst(rst),
        .issueReq(issueReq),
        .issueAck(issueAck),
        .issueUop(issueUop),
        .laneIdle(laneIdle),
        .laneStart(laneStart),
        .laneUop(laneUop)
    );

    // All lanes share the uop bus. Only the started lane latches it.
    for (genvar i = 0; i < NUM_LANES; i++) begin : gLane
        divLane lane (
            .clk(clk),
            .rst(rst),
            .laneStart(laneStart[i]),
            .laneUop(laneUop),
            .branch(branch),
            .laneIdle(laneIdle[i]),
            .laneDone(laneDone[i]),
            .laneRes(laneRes[i]),
            .laneGrant(laneGrant[i])
        );
    end

    divResultArbiter arbiter (
        .clk(clk),
        .rst(rst),
        .laneDone(laneDone),
        .laneRes(laneRes),
        .laneGrant(laneGrant),
        .resReq(resReq),
        .resAck(resAck),
        .res(res)
    );

endmodule

`default_nettype wire

// ==== tb/divClusterTb.sv ====
`default_nettype none

module divClusterTb import divPkg::*; ();

    localparam int WAIT_LIMIT = 2000;  // Longest any single wait may take, in cycles.

    logic clk = 1'b0;
    logic rst;
    logic issueReq;
    logic issueAck;
    divUop issueUop;
    branchProv branch;
    logic resReq;
    logic resAck;
    divResult res;

    // Scoreboard indexed by tag.
    logic [DATA_W-1:0] expected [2**TAG_W];
    logic [SQN_W-1:0] expectedSqN [2**TAG_W];
    logic pending [2**TAG_W];
    int outstanding = 0;
    int mismatches = 0;
    int failures = 0;
    logic [SQN_W-1:0] nextSqN = '0;
    logic drained = 1'b0;

    divCluster dut (
        .clk(clk),
        .rst(rst),
        .issueReq(issueReq),
        .issueAck(issueAck),
        .issueUop(issueUop),
        .branch(branch),
        .resReq(resReq),
        .resAck(resAck),
        .res(res)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Division as the RISC-V rules define it, including the two special cases.
    function automatic logic [DATA_W-1:0] refDiv(
        input divOp op,
        input logic [DATA_W-1:0] a,
        input logic [DATA_W-1:0] b
    );
        logic isQuot;
        isQuot = (op == DIV_DIV) || (op == DIV_DIVU);
        if (b == '0) begin
            return isQuot ? '1 : a;
        end
        if ((op == DIV_DIV || op == DIV_REM) && a == DATA_MIN && b == '1) begin
            return isQuot ? a : '0;
        end
        case (op)
            DIV_DIV: return $signed(a) / $signed(b);
            DIV_REM: return $signed(a) % $signed(b);  // Sign follows the dividend.
            DIV_DIVU: return a / b;
            default: return a % b;
        endcase
    endfunction

    task automatic checkValue(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] want,
                              input string what);
        if (got !== want) begin
            $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, want);
            mismatches++;
        end
    endtask

    task automatic finishRun();
        $display("Run ended with %0d mismatches and %0d other errors.", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    task automatic reportStall(input string what);
        $display("Timeout at %0t: %s.", $time, what);
        failures++;
        finishRun();
    endtask

    task automatic sendUop(
        input logic [SQN_W-1:0] sq,
        input divOp op,
        input logic [DATA_W-1:0] a,
        input logic [DATA_W-1:0] b
    );
        divUop u;
        int n;
        u.sqN = sq;
        u.tag = sq[TAG_W-1:0];
        u.op = op;
        u.srcA = a;
        u.srcB = b;
        @(posedge clk);
        issueReq <= 1'b1;
        issueUop <= u;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > WAIT_LIMIT) reportStall("issueAck never rose");
        end while (!issueAck);
        issueReq <= 1'b0;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > WAIT_LIMIT) reportStall("issueAck never fell");
        end while (issueAck);
    endtask

    task automatic issueChecked(input divOp op, input logic [DATA_W-1:0] a,
                                input logic [DATA_W-1:0] b, input logic [DATA_W-1:0] want);
        logic [SQN_W-1:0] sq;
        sq = nextSqN;
        nextSqN = nextSqN + 1'b1;
        if (pending[sq[TAG_W-1:0]]) begin
            $display("Tag %0d was reused while its result was still pending.", sq[TAG_W-1:0]);
            failures++;
        end
        expected[sq[TAG_W-1:0]] = want;
        expectedSqN[sq[TAG_W-1:0]] = sq;
        pending[sq[TAG_W-1:0]] = 1'b1;
        outstanding++;
        sendUop(sq, op, a, b);
    endtask

    task automatic claimResult(input divResult got);
        if (!pending[got.tag]) begin
            $display("Unexpected result for tag %0d at %0t.", got.tag, $time);
            failures++;
        end else begin
            checkValue(got.result, expected[got.tag], $sformatf("result of uop %0d", got.sqN));
            checkValue(DATA_W'(got.sqN), DATA_W'(expectedSqN[got.tag]),
                       $sformatf("sqN for tag %0d", got.tag));
            pending[got.tag] = 1'b0;
            outstanding--;
        end
    endtask

    initial begin : stimulus
        int fd;
        int n;
        int waitCnt;
        string line;
        logic [3:0] opVal;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic [DATA_W-1:0] want;
        logic [3:0] flush;
        logic [31:0] rs;
        logic [SQN_W-1:0] sq;
        divOp op;

        rst = 1'b0;
        issueReq = 1'b0;
        issueUop = '0;
        branch = '0;
        for (int t = 0; t < 2**TAG_W; t++) begin
            pending[t] = 1'b0;
        end
        repeat (4) @(posedge clk);
        rst <= 1'b1;

        fd = $fopen("tb/divTests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test file tb/divTests.txt.");
            failures++;
            finishRun();
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 9 || line[0] == "#") continue;
            n = $sscanf(line, "%h %h %h %h %h", opVal, a, b, flush, want);
            if (n != 5) begin
                $display("Test file line could not be read: %s", line);
                failures++;
            end else if (flush[0]) begin
                waitCnt = 0;
                while (outstanding >= NUM_LANES) begin  // Make sure a lane takes it at once.
                    @(posedge clk);
                    waitCnt++;
                    if (waitCnt > WAIT_LIMIT) reportStall("lanes never freed before a flush");
                end
                sq = nextSqN;
                nextSqN = nextSqN + 1'b1;
                sendUop(sq, divOp'(opVal[1:0]), a, b);
                repeat (3) @(posedge clk);
                branch <= {1'b1, sq - 1'b1};  // Older uops survive, this one is killed.
                @(posedge clk);
                branch <= '0;
            end else begin
                issueChecked(divOp'(opVal[1:0]), a, b, want);
            end
        end
        $fclose(fd);

        rs = 32'd35;
        repeat (40) begin
            rs = lcgNext(rs);
            op = divOp'(rs[29:28]);
            rs = lcgNext(rs);
            a = rs;
            rs = lcgNext(rs);
            b = (rs[7:5] == 3'd0) ? '0 : rs >> rs[4:0];
            issueChecked(op, a, b, refDiv(op, a, b));
        end

        waitCnt = 0;
        while (outstanding > 0) begin
            @(posedge clk);
            waitCnt++;
            if (waitCnt > WAIT_LIMIT) begin
                $display("Timeout at %0t: results never drained.", $time);
                failures++;
                break;
            end
        end
        repeat (50) @(posedge clk);  // A stray result would still show up here.
        drained = 1'b1;
        for (int t = 0; t < 2**TAG_W; t++) begin
            if (pending[t]) begin
                $display("No result ever came for tag %0d.", t);
                failures++;
            end
        end
        finishRun();
    end

    initial begin : resultSide
        logic [31:0] rs;
        divResult got;
        int idle;
        int n;

        rs = 32'd35;
        idle = 0;
        resAck = 1'b0;
        while (!drained) begin
            @(posedge clk);
            if (resReq) begin
                idle = 0;
                got = res;
                rs = lcgNext(rs);
                repeat (rs[31:16] % 6) @(posedge clk);
                resAck <= 1'b1;
                n = 0;
                do begin
                    @(posedge clk);
                    n++;
                    if (n > WAIT_LIMIT) reportStall("resReq never fell after resAck");
                end while (resReq);
                resAck <= 1'b0;
                claimResult(got);
            end else if (outstanding > 0) begin
                idle++;
                if (idle > WAIT_LIMIT) reportStall("no resReq while results were outstanding");
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb/divTests.txt ====
# op srcA srcB flush expected, all hex; op 0 div, 1 divu, 2 rem, 3 remu
# A flush line is killed by a taken branch just older than it, so its expected value is unused.
0 00000064 00000007 0 0000000e
0 ffffff9c 00000007 0 fffffff2
0 00000064 fffffff9 0 fffffff2
0 ffffff9c fffffff9 0 0000000e
2 00000064 00000007 0 00000002
2 ffffff9c 00000007 0 fffffffe
2 00000064 fffffff9 0 00000002
2 ffffff9c fffffff9 0 fffffffe
1 ffffff9c 00000007 0 24924916
3 ffffff9c 00000007 0 00000002
1 00000064 fffffff9 0 00000000
3 00000064 fffffff9 0 00000064
0 00001234 00000000 0 ffffffff
1 80000000 00000000 0 ffffffff
2 ffffff9c 00000000 0 ffffff9c
3 00001234 00000000 0 00001234
0 80000000 ffffffff 0 80000000
2 80000000 ffffffff 0 00000000
1 80000000 ffffffff 0 00000000
3 80000000 ffffffff 0 80000000
1 00000064 00000007 0 0000000e
3 00000064 00000007 0 00000002
0 00000005 00000001 1 00000000
0 80000000 00000002 0 c0000000
0 7fffffff 00000001 0 7fffffff
2 7fffffff 0000000a 0 00000007
1 ffffffff ffffffff 0 00000001
0 00000000 00000005 0 00000000
0 ffffffff 00000002 0 00000000
2 ffffffff 00000002 1 00000000
2 ffffffff 00000002 0 ffffffff
3 deadbeef 00010000 0 0000beef
1 deadbeef 00010000 0 0000dead
0 fffffff9 00000002 0 fffffffd
2 fffffff9 00000002 0 ffffffff

// ==== sim.f ====
logic/divPkg.sv
logic/divDispatch.sv
logic/divLane.sv
logic/divResultArbiter.sv
logic/divCluster.sv
tb/divClusterTb.sv
